// ==== icache_pkg.sv ====
package icache_pkg;

    parameter int ADDR_W = 32;
    parameter int WORD_W = 32;
    parameter int WORDS_PER_LINE = 8;
    parameter int OFFSET_W = 5;
    parameter int LINE_W = WORDS_PER_LINE * WORD_W;  // 256
    parameter int WORD_SEL_W = $clog2(WORDS_PER_LINE);
    // wide enough for index or tag under any split of the line address
    parameter int LINE_ADDR_W = ADDR_W - OFFSET_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;  // word i at bits i*32 up

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;
        addr_t             pc;
        logic [WORD_W-1:0] inst_a;
        logic [WORD_W-1:0] inst_b;
    } fetch_resp_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } refill_t;

    typedef struct packed {
        logic              hit;
        logic [WORD_W-1:0] word;
    } way_port_t;

    typedef struct packed {
        logic [1:0]             we;     // bit 0 serves A, bit 1 serves B
        logic [LINE_ADDR_W-1:0] index;  // low INDEX_W bits used
        logic [LINE_ADDR_W-1:0] tag;    // low tag-width bits used
    } fill_t;

    typedef struct packed {
        logic                   valid;
        logic                   way;
        logic [LINE_ADDR_W-1:0] index;  // low INDEX_W bits used
    } lru_ev_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MISS_A,
        S_MISS_B,
        S_RETURN
    } cache_state_e;

endpackage

// ==== icache_lru.sv ====
`timescale 1ns/10ps

module icache_lru #(
    parameter int INDEX_W = 7
) (
    input  logic                clk,
    input  logic                reset,
    input  icache_pkg::lru_ev_t hit_a,
    input  icache_pkg::lru_ev_t hit_b,
    input  icache_pkg::lru_ev_t fill_ev,
    input  logic [INDEX_W-1:0]  victim_index,
    output logic                victim
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0]    lru_q;  // way to replace next
    logic [INDEX_W-1:0] hit_a_index;
    logic [INDEX_W-1:0] hit_b_index;
    logic [INDEX_W-1:0] fill_index;

    assign hit_a_index = hit_a.index[INDEX_W-1:0];
    assign hit_b_index = hit_b.index[INDEX_W-1:0];
    assign fill_index = fill_ev.index[INDEX_W-1:0];

    // fills and hits never coincide, B applied after A on a shared set
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else begin
            if (fill_ev.valid) begin
                lru_q[fill_index] <= ~fill_ev.way;
            end
            if (hit_a.valid) begin
                lru_q[hit_a_index] <= ~hit_a.way;
            end
            if (hit_b.valid) begin
                lru_q[hit_b_index] <= ~hit_b.way;
            end
        end
    end

    assign victim = lru_q[victim_index];

endmodule

// ==== icache_way.sv ====
`timescale 1ns/10ps

module icache_way #(
    parameter int INDEX_W = 7,
    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [INDEX_W-1:0]                index_a,
    input  logic [INDEX_W-1:0]                index_b,
    input  logic [TAG_W-1:0]                  tag_a,
    input  logic [TAG_W-1:0]                  tag_b,
    input  icache_pkg::fill_t                 fill,
    input  logic                              fill_en,
    input  icache_pkg::line_t                 fill_data,
    input  logic [icache_pkg::WORD_SEL_W-1:0] offset_a,
    input  logic [icache_pkg::WORD_SEL_W-1:0] offset_b,
    output icache_pkg::way_port_t             port_a,
    output icache_pkg::way_port_t             port_b
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0]   valid_q;
    logic [TAG_W-1:0]  tag_mem [SETS];
    icache_pkg::line_t line_mem [SETS];
    logic              valid_rd_a;
    logic              valid_rd_b;
    logic [TAG_W-1:0]  tag_rd_a;
    logic [TAG_W-1:0]  tag_rd_b;
    icache_pkg::line_t line_rd_a;
    icache_pkg::line_t line_rd_b;
    logic              wr;
    logic [INDEX_W-1:0] wr_index;

    assign wr = fill_en & (|fill.we);
    assign wr_index = fill.index[INDEX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wr) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_rd_a <= 1'b0;
            valid_rd_b <= 1'b0;
        end else begin
            valid_rd_a <= valid_q[index_a];
            valid_rd_b <= valid_q[index_b];
        end
    end

    // read returns old contents when the same set is written
    always_ff @(posedge clk) begin
        if (wr) begin
            tag_mem[wr_index] <= fill.tag[TAG_W-1:0];
            line_mem[wr_index] <= fill_data;
        end
        tag_rd_a <= tag_mem[index_a];
        tag_rd_b <= tag_mem[index_b];
        line_rd_a <= line_mem[index_a];
        line_rd_b <= line_mem[index_b];
    end

    // compare against the tags of the request now in flight
    always_comb begin
        port_a.hit = valid_rd_a & (tag_rd_a == tag_a);
        port_a.word = line_rd_a[offset_a * icache_pkg::WORD_W +: icache_pkg::WORD_W];
        port_b.hit = valid_rd_b & (tag_rd_b == tag_b);
        port_b.word = line_rd_b[offset_b * icache_pkg::WORD_W +: icache_pkg::WORD_W];
    end

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl #(
    parameter int INDEX_W = 7,
    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W
) (
    input  logic                              clk,
    input  logic                              reset,
    input  icache_pkg::fetch_req_t            req,
    input  logic                              branch_flush,
    input  icache_pkg::refill_t               ret,
    output logic                              stall,
    output icache_pkg::fetch_resp_t           resp,
    output logic                              rd_req,
    output icache_pkg::addr_t                 rd_addr,
    output logic [INDEX_W-1:0]                index_a,
    output logic [INDEX_W-1:0]                index_b,
    output logic [TAG_W-1:0]                  tag_a,
    output logic [TAG_W-1:0]                  tag_b,
    output logic [icache_pkg::WORD_SEL_W-1:0] offset_a,
    output logic [icache_pkg::WORD_SEL_W-1:0] offset_b,
    output icache_pkg::fill_t                 fill,
    input  icache_pkg::way_port_t             way0_a,
    input  icache_pkg::way_port_t             way0_b,
    input  icache_pkg::way_port_t             way1_a,
    input  icache_pkg::way_port_t             way1_b,
    input  logic                              victim,
    output icache_pkg::lru_ev_t               lru_hit_a,
    output icache_pkg::lru_ev_t               lru_hit_b,
    output icache_pkg::lru_ev_t               lru_fill
);

    localparam int LA_W = icache_pkg::LINE_ADDR_W;
    localparam int WSEL_LO = icache_pkg::OFFSET_W - icache_pkg::WORD_SEL_W;

    icache_pkg::cache_state_e state;
    icache_pkg::cache_state_e next_state;
    logic                     valid_q;
    logic                     drop_q;
    icache_pkg::addr_t        addr_a_q;
    icache_pkg::addr_t        addr_b_q;
    icache_pkg::addr_t        req_pc_b;
    icache_pkg::addr_t        miss_addr;
    logic                     hit_a;
    logic                     hit_b;
    logic                     same_line;
    logic                     ret_ok;
    logic                     refilling;
    logic                     lookup;

    assign hit_a = way0_a.hit | way1_a.hit;
    assign hit_b = way0_b.hit | way1_b.hit;
    assign req_pc_b = req.pc + 4;
    assign same_line = addr_a_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W] ==
                       addr_b_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];
    assign ret_ok = ret.valid & ~drop_q & ~branch_flush;  // return owed to this request
    assign refilling = (state == icache_pkg::S_MISS_A) | (state == icache_pkg::S_MISS_B);
    assign lookup = (state == icache_pkg::S_IDLE) & valid_q & ~branch_flush;

    always_comb begin
        next_state = state;
        if (branch_flush) begin
            next_state = icache_pkg::S_IDLE;
        end else begin
            case (state)
                icache_pkg::S_IDLE: begin
                    if (valid_q && !hit_a) begin
                        next_state = icache_pkg::S_MISS_A;
                    end else if (valid_q && !hit_b) begin
                        next_state = icache_pkg::S_MISS_B;
                    end
                end
                icache_pkg::S_MISS_A: begin
                    if (ret_ok && (same_line || hit_b)) begin
                        next_state = icache_pkg::S_RETURN;  // one line covers both words
                    end else if (ret_ok) begin
                        next_state = icache_pkg::S_MISS_B;
                    end
                end
                icache_pkg::S_MISS_B: begin
                    if (ret_ok) begin
                        next_state = icache_pkg::S_RETURN;
                    end
                end
                default: begin
                    next_state = icache_pkg::S_IDLE;  // re-read done, answer next cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= icache_pkg::S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // held high through the miss and the re-read cycle
    assign stall = (state != icache_pkg::S_IDLE) | (next_state != icache_pkg::S_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= req.valid;
        end else if (branch_flush) begin
            valid_q <= 1'b0;  // abandon request
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && req.valid) begin
            addr_a_q <= req.pc;
            addr_b_q <= req_pc_b;
        end
    end

    // a refill still in flight at flush time comes back later and is thrown away
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_q <= 1'b0;
        end else if (branch_flush && rd_req && !ret.valid) begin
            drop_q <= 1'b1;
        end else if (ret.valid) begin
            drop_q <= 1'b0;
        end
    end

    assign miss_addr = (state == icache_pkg::S_MISS_A) ? addr_a_q : addr_b_q;
    assign rd_req = refilling & ~drop_q;
    assign rd_addr = {miss_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                      {icache_pkg::OFFSET_W{1'b0}}};

    // array read address follows the incoming pc unless held
    assign index_a = stall ? addr_a_q[icache_pkg::OFFSET_W +: INDEX_W]
                           : req.pc[icache_pkg::OFFSET_W +: INDEX_W];
    assign index_b = stall ? addr_b_q[icache_pkg::OFFSET_W +: INDEX_W]
                           : req_pc_b[icache_pkg::OFFSET_W +: INDEX_W];
    assign tag_a = addr_a_q[icache_pkg::ADDR_W-1 -: TAG_W];
    assign tag_b = addr_b_q[icache_pkg::ADDR_W-1 -: TAG_W];
    assign offset_a = addr_a_q[WSEL_LO +: icache_pkg::WORD_SEL_W];
    assign offset_b = addr_b_q[WSEL_LO +: icache_pkg::WORD_SEL_W];

    always_comb begin
        fill.we = 2'b00;
        fill.index = LA_W'(miss_addr[icache_pkg::OFFSET_W +: INDEX_W]);
        fill.tag = LA_W'(miss_addr[icache_pkg::ADDR_W-1 -: TAG_W]);
        if (ret_ok && state == icache_pkg::S_MISS_A) begin
            fill.we = {same_line, 1'b1};
        end else if (ret_ok && state == icache_pkg::S_MISS_B) begin
            fill.we = 2'b10;
        end
    end

    always_comb begin
        lru_fill.valid = ret_ok & refilling;
        lru_fill.way = victim;
        lru_fill.index = fill.index;
        lru_hit_a.valid = lookup & hit_a;
        lru_hit_a.way = way1_a.hit;
        lru_hit_a.index = LA_W'(addr_a_q[icache_pkg::OFFSET_W +: INDEX_W]);
        lru_hit_b.valid = lookup & hit_b;
        lru_hit_b.way = way1_b.hit;
        lru_hit_b.index = LA_W'(addr_b_q[icache_pkg::OFFSET_W +: INDEX_W]);
    end

    always_comb begin
        resp.valid = lookup & hit_a & hit_b;
        resp.pc = addr_a_q;
        resp.inst_a = way0_a.hit ? way0_a.word : way1_a.word;
        resp.inst_b = way0_b.hit ? way0_b.word : way1_b.word;
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/10ps

module icache_top #(
    parameter int INDEX_W = 7,
    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  icache_pkg::fetch_req_t  req,
    output logic                    stall,
    output icache_pkg::fetch_resp_t resp,
    output logic                    rd_req,
    output icache_pkg::addr_t       rd_addr,
    input  icache_pkg::refill_t     ret,
    input  logic                    branch_flush
);

    logic [INDEX_W-1:0]                index_a;
    logic [INDEX_W-1:0]                index_b;
    logic [TAG_W-1:0]                  tag_a;
    logic [TAG_W-1:0]                  tag_b;
    logic [icache_pkg::WORD_SEL_W-1:0] offset_a;
    logic [icache_pkg::WORD_SEL_W-1:0] offset_b;
    icache_pkg::fill_t                 fill;
    icache_pkg::way_port_t             way0_a;
    icache_pkg::way_port_t             way0_b;
    icache_pkg::way_port_t             way1_a;
    icache_pkg::way_port_t             way1_b;
    icache_pkg::lru_ev_t               lru_hit_a;
    icache_pkg::lru_ev_t               lru_hit_b;
    icache_pkg::lru_ev_t               lru_fill;
    logic                              victim;

    icache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .branch_flush (branch_flush),
        .ret          (ret),
        .stall        (stall),
        .resp         (resp),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .index_a      (index_a),
        .index_b      (index_b),
        .tag_a        (tag_a),
        .tag_b        (tag_b),
        .offset_a     (offset_a),
        .offset_b     (offset_b),
        .fill         (fill),
        .way0_a       (way0_a),
        .way0_b       (way0_b),
        .way1_a       (way1_a),
        .way1_b       (way1_b),
        .victim       (victim),
        .lru_hit_a    (lru_hit_a),
        .lru_hit_b    (lru_hit_b),
        .lru_fill     (lru_fill)
    );

    icache_way #(.INDEX_W(INDEX_W)) u_way0 (
        .clk       (clk),
        .reset     (reset),
        .index_a   (index_a),
        .index_b   (index_b),
        .tag_a     (tag_a),
        .tag_b     (tag_b),
        .fill      (fill),
        .fill_en   (~victim),
        .fill_data (ret.data),
        .offset_a  (offset_a),
        .offset_b  (offset_b),
        .port_a    (way0_a),
        .port_b    (way0_b)
    );

    icache_way #(.INDEX_W(INDEX_W)) u_way1 (
        .clk       (clk),
        .reset     (reset),
        .index_a   (index_a),
        .index_b   (index_b),
        .tag_a     (tag_a),
        .tag_b     (tag_b),
        .fill      (fill),
        .fill_en   (victim),
        .fill_data (ret.data),
        .offset_a  (offset_a),
        .offset_b  (offset_b),
        .port_a    (way1_a),
        .port_b    (way1_b)
    );

    icache_lru #(.INDEX_W(INDEX_W)) u_lru (
        .clk          (clk),
        .reset        (reset),
        .hit_a        (lru_hit_a),
        .hit_b        (lru_hit_b),
        .fill_ev      (lru_fill),
        .victim_index (fill.index[INDEX_W-1:0]),  // set of the line being refilled
        .victim       (victim)
    );

endmodule

// ==== icache_assertions.sv ====
`timescale 1ns/10ps

module icache_assertions (
    input logic                    clk,
    input logic                    reset,
    input logic                    stall,
    input logic                    rd_req,
    input icache_pkg::addr_t       rd_addr,
    input icache_pkg::fetch_resp_t resp
);

    refill_needs_stall: assert property (
        @(posedge clk) disable iff (reset) rd_req |-> stall
    ) else $error("rd_req high while stall is low");

    resp_without_stall: assert property (
        @(posedge clk) disable iff (reset) resp.valid |-> !stall
    ) else $error("resp.valid high while stall is high");

    line_aligned_refill: assert property (
        @(posedge clk) disable iff (reset)
        rd_req |-> (rd_addr[icache_pkg::OFFSET_W-1:0] == '0)
    ) else $error("rd_addr not line aligned");

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    always #50 clk = ~clk;  // 100 ns period

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker #(
    parameter int INDEX_W = 7
) (
    input logic                    clk,
    input logic                    reset,
    input logic [31:0]             key,
    input icache_pkg::fetch_req_t  req,
    input logic                    branch_flush,
    input logic                    ret_valid,
    input logic                    stall,
    input icache_pkg::fetch_resp_t resp,
    input logic                    rd_req,
    input icache_pkg::addr_t       rd_addr
);

    localparam int SETS = 1 << INDEX_W;

    typedef enum logic [1:0] {M_IDLE, M_MISS_A, M_MISS_B, M_RETURN} model_state_e;

    int           error_count = 0;
    int           check_count = 0;
    int           mark_errors = 0;
    int           mark_checks = 0;
    model_state_e m_state;
    model_state_e m_next;
    logic         m_valid;
    logic         m_drop;
    logic [31:0]  m_a;
    logic [31:0]  m_b;
    logic [31:0]  miss_addr;
    logic         line_valid [2][SETS];
    logic [26:0]  line_tag [2][SETS];
    logic         lru [SETS];  // way to replace next
    int           way_a;
    int           way_b;
    int           set_idx;
    logic         victim;
    logic         ret_ok;
    logic         lookup;
    logic         refilling;
    logic         exp_stall;
    logic         exp_rd_req;
    logic         exp_resp;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ key;
    endfunction

    function automatic int find_way(input logic [31:0] addr);
        int s;
        s = int'(addr[5 +: INDEX_W]);
        for (int w = 0; w < 2; w++) begin
            if (line_valid[w][s] && line_tag[w][s] == addr[31:5]) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] got);
        check_count++;
        if (expected !== got) begin
            error_count++;
            $display("** Error at %0t: %s expected %h got %h", $time, what, expected, got);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, check_count - mark_checks,
                 error_count - mark_errors);
        mark_checks = check_count;
        mark_errors = error_count;
    endtask

    task automatic report_final();
        $display("total: %0d checks, %0d errors", check_count, error_count);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            m_state = M_IDLE;
            m_valid = 1'b0;
            m_drop = 1'b0;
            m_a = '0;
            for (int s = 0; s < SETS; s++) begin
                line_valid[0][s] = 1'b0;
                line_valid[1][s] = 1'b0;
                lru[s] = 1'b0;
            end
        end else begin
            m_b = m_a + 4;
            way_a = find_way(m_a);
            way_b = find_way(m_b);
            ret_ok = ret_valid && !m_drop && !branch_flush;
            lookup = (m_state == M_IDLE) && m_valid && !branch_flush;
            refilling = (m_state == M_MISS_A) || (m_state == M_MISS_B);
            m_next = m_state;
            if (branch_flush) begin
                m_next = M_IDLE;
            end else if (m_state == M_IDLE && m_valid) begin
                if (way_a < 0) begin
                    m_next = M_MISS_A;
                end else if (way_b < 0) begin
                    m_next = M_MISS_B;
                end
            end else if (m_state == M_MISS_A && ret_ok) begin
                // one line serves both when B shares it or already hits
                m_next = (m_a[31:5] == m_b[31:5] || way_b >= 0) ? M_RETURN : M_MISS_B;
            end else if (m_state == M_MISS_B && ret_ok) begin
                m_next = M_RETURN;
            end else if (m_state == M_RETURN) begin
                m_next = M_IDLE;
            end
            exp_stall = (m_state != M_IDLE) || (m_next != M_IDLE);
            exp_rd_req = refilling && !m_drop;
            exp_resp = lookup && way_a >= 0 && way_b >= 0;
            miss_addr = (m_state == M_MISS_A) ? m_a : m_b;

            check_value("stall", 32'(exp_stall), 32'(stall));
            check_value("resp.valid", 32'(exp_resp), 32'(resp.valid));
            check_value("rd_req", 32'(exp_rd_req), 32'(rd_req));
            if (exp_rd_req && rd_req) begin
                check_value("rd_addr", {miss_addr[31:5], 5'b0}, rd_addr);
            end
            if (exp_resp && resp.valid) begin
                check_value("resp.pc", m_a, resp.pc);
                check_value("inst_a", mem_word(m_a), resp.inst_a);
                check_value("inst_b", mem_word(m_b), resp.inst_b);
            end

            if (lookup && way_a >= 0) begin
                lru[m_a[5 +: INDEX_W]] = (way_a == 0);
            end
            if (lookup && way_b >= 0) begin
                lru[m_b[5 +: INDEX_W]] = (way_b == 0);
            end
            if (ret_ok && refilling) begin
                set_idx = int'(miss_addr[5 +: INDEX_W]);
                victim = lru[set_idx];
                line_valid[victim][set_idx] = 1'b1;
                line_tag[victim][set_idx] = miss_addr[31:5];
                lru[set_idx] = ~victim;
            end
            if (branch_flush && exp_rd_req && !ret_valid) begin
                m_drop = 1'b1;  // owed return will be ignored
            end else if (ret_valid) begin
                m_drop = 1'b0;
            end
            if (!exp_stall) begin
                m_valid = req.valid;
                if (req.valid) begin
                    m_a = req.pc;
                end
            end else if (branch_flush) begin
                m_valid = 1'b0;
            end
            m_state = m_next;
        end
    end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

    localparam int INDEX_W = 7;
    localparam int WAIT_LIMIT = 200;

    logic                    clk;
    logic                    reset;
    icache_pkg::fetch_req_t  req;
    logic                    stall;
    icache_pkg::fetch_resp_t resp;
    logic                    rd_req;
    icache_pkg::addr_t       rd_addr;
    icache_pkg::refill_t     ret;
    logic                    branch_flush;
    logic [31:0]             key;
    logic [31:0]             pend_addr;
    int                      countdown;

    tb_clock u_clock (.clk(clk), .reset(reset));

    icache_top #(.INDEX_W(INDEX_W)) u_icache_top (
        .clk(clk), .reset(reset), .req(req), .stall(stall), .resp(resp),
        .rd_req(rd_req), .rd_addr(rd_addr), .ret(ret), .branch_flush(branch_flush)
    );

    tb_checker #(.INDEX_W(INDEX_W)) u_checker (
        .clk(clk), .reset(reset), .key(key), .req(req), .branch_flush(branch_flush),
        .ret_valid(ret.valid), .stall(stall), .resp(resp), .rd_req(rd_req),
        .rd_addr(rd_addr)
    );

    bind icache_ctrl icache_assertions u_assertions (
        .clk(clk), .reset(reset), .stall(stall), .rd_req(rd_req),
        .rd_addr(rd_addr), .resp(resp)
    );

    task automatic end_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $finish;
    endtask

    function automatic logic [31:0] rand_pc();
        logic [31:0] tag_sel;
        logic [31:0] set_sel;
        logic [31:0] word_sel;
        tag_sel = $urandom % 4;
        set_sel = $urandom % 4;
        word_sel = $urandom % 8;
        return 32'h0001_0000 + tag_sel * 4096 + set_sel * 32 + word_sel * 4;
    endfunction

    task automatic fetch(input logic [31:0] pc);
        int waited;
        @(negedge clk);
        req.valid = 1'b1;
        req.pc = pc;
        branch_flush = 1'b0;
        waited = 0;
        @(posedge clk);
        while (stall) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                end_on_timeout("request acceptance");
            end
            @(posedge clk);
        end
    endtask

    task automatic idle_cycle(input logic flush);
        @(negedge clk);
        req.valid = 1'b0;
        branch_flush = flush;
    endtask

    task automatic drain();
        int waited;
        idle_cycle(1'b0);
        waited = 0;
        @(posedge clk);
        while (stall || countdown != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                end_on_timeout("cache to go idle");
            end
            @(posedge clk);
        end
    endtask

    // memory model, one outstanding refill at a time
    initial begin
        ret = '0;
        countdown = 0;
        forever begin
            @(negedge clk);
            ret.valid = 1'b0;
            if (reset) begin
                countdown = 0;
            end else if (countdown > 0) begin
                countdown--;
                if (countdown == 0) begin
                    ret.valid = 1'b1;
                    for (int k = 0; k < 8; k++) begin
                        ret.data[k*32 +: 32] = (pend_addr + 32'(4 * k)) ^ key;
                    end
                end
            end else if (rd_req) begin
                pend_addr = rd_addr;
                countdown = 1 + int'($urandom % 6);
            end
        end
    end

    initial begin
        int waited;
        req = '0;
        branch_flush = 1'b0;
        void'($urandom(32'hf3f1ba4d));
        key = $urandom();
        waited = 0;
        while (reset !== 1'b0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                end_on_timeout("reset release");
            end
            @(negedge clk);
        end

        for (int i = 0; i < 300; i++) begin
            fetch(rand_pc());
            if ($urandom % 8 == 0) begin
                idle_cycle(1'b0);
            end
        end
        drain();
        u_checker.report_test("random fetch");

        // three lines in set 40, then re-access
        fetch(32'h0004_0500);
        fetch(32'h0004_1500);
        fetch(32'h0004_2500);
        fetch(32'h0004_0500);
        fetch(32'h0004_2500);
        fetch(32'h0004_1500);
        fetch(32'h0004_0500);
        drain();
        u_checker.report_test("lru replacement");

        for (int i = 0; i < 200; i++) begin
            fetch(rand_pc());
            if ($urandom % 6 == 0) begin
                repeat ($urandom % 4) idle_cycle(1'b0);
                idle_cycle(1'b1);
            end
        end
        drain();
        repeat (4) idle_cycle(1'b0);
        u_checker.report_test("branch flush");

        u_checker.report_final();
        if (u_checker.error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
icache_pkg.sv
icache_lru.sv
icache_way.sv
icache_ctrl.sv
icache_top.sv
icache_assertions.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f project.f -o tb_sim

./obj_dir/tb_sim > sim.log
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    exit 1
fi
